// File: all.f
mos_bus_pkg.sv
mos_isa_pkg.sv
cpu_alu.sv
cpu_decode.sv
cpu_regfile.sv
cpu_sequencer.sv
cpu_top.sv
tb_clock.sv
cpu_checker.sv
tb_cpu.sv

// File: cpu_alu.sv
`default_nettype none

module cpu_alu (
    input  wire mos_isa_pkg::alu_op_t op,
    input  wire mos_bus_pkg::data_t   a_in,
    input  wire mos_bus_pkg::data_t   b_in,
    input  wire mos_isa_pkg::flags_t  flags_in,
    output mos_bus_pkg::data_t        result,
    output mos_isa_pkg::flags_t       flags_out
);
    import mos_bus_pkg::*;
    import mos_isa_pkg::*;

    data_t      b_eff;                      // B, inverted for subtracts
    logic       carry_in;
    logic [8:0] sum;                        // Adder with carry out
    logic       flag_only;                  // CLC, SEC, CLV

    always_comb begin
        b_eff     = (op == SBC || op == CMP) ? ~b_in : b_in;
        carry_in  = (op == CMP) ? 1'b1 : flags_in[FLAG_C];   // CMP ignores C
        sum       = {1'b0, a_in} + {1'b0, b_eff} + {8'h00, carry_in};
        flag_only = (op == CLC || op == SEC || op == CLV);

        result    = b_in;                   // PASS by default
        flags_out = flags_in;

        case (op)
            ORA: result = a_in | b_in;
            AND: result = a_in & b_in;
            EOR: result = a_in ^ b_in;
            ADC, SBC: begin
                result            = sum[7:0];
                flags_out[FLAG_C] = sum[8];
                // Signed overflow when inputs agree and sum differs
                flags_out[FLAG_V] = (a_in[7] == b_eff[7]) && (sum[7] != a_in[7]);
            end
            CMP: begin
                result            = sum[7:0];   // Difference, never written back
                flags_out[FLAG_C] = sum[8];     // Set when a_in >= b_in
            end
            INC: result = a_in + 8'd1;
            DEC: result = a_in - 8'd1;
            CLC: flags_out[FLAG_C] = 1'b0;
            SEC: flags_out[FLAG_C] = 1'b1;
            CLV: flags_out[FLAG_V] = 1'b0;
            default: result = b_in;
        endcase

        if (!flag_only) begin
            flags_out[FLAG_Z] = (result == 8'h00);
            flags_out[FLAG_N] = result[7];
        end
    end

endmodule

`default_nettype wire

// File: cpu_checker.sv
`default_nettype none

module cpu_checker (
    input wire                     CLK,
    input wire                     RESET,
    input wire mos_bus_pkg::addr_t bus_addr,
    input wire                     bus_we,
    input wire                     bus_ready,
    input wire                     sync
);
    // Bus rules ------------------------------
    // Completed write goes straight to the next opcode fetch
    write_then_fetch: assert property (@(posedge CLK) disable iff (RESET)
        bus_we && bus_ready |=> sync && !bus_we)
        else $error("completed write not followed by a write-free opcode fetch");

    stall_holds_bus: assert property (@(posedge CLK) disable iff (RESET)
        !bus_ready |=> $stable(bus_addr) && $stable(bus_we))
        else $error("bus changed during a stall");

    // First edge may still show the power-up state
    no_sync_in_reset: assert property (@(posedge CLK)
        RESET && $past(RESET) |-> !sync)
        else $error("sync high during reset");

endmodule

bind cpu_top cpu_checker cpu_checker_i (.*);

`default_nettype wire

// File: cpu_decode.sv
`default_nettype none

module cpu_decode (
    input  wire mos_isa_pkg::opcode_t    opcode,
    input  wire mos_isa_pkg::seq_state_t state,
    output mos_isa_pkg::alu_op_t         alu_op,
    output mos_isa_pkg::reg_sel_t        dst_sel,
    output mos_isa_pkg::reg_sel_t        src_sel,
    output logic                         operand_sel,
    output logic                         reg_we,
    output logic                         flags_we,
    output logic                         store
);
    import mos_isa_pkg::*;

    logic exec;                             // Execute cycle of the sequence
    logic write_en;
    logic flags_en;

    // Stores ------------------------------
    // STA/STX/STY zp and abs, cc picks the source register
    assign store = (opcode[7:5] == 3'b100)
                && (opcode[4:2] == 3'b001 || opcode[4:2] == 3'b011)
                && (opcode[1:0] != 2'b11);

    assign exec     = (state == IMM_EXEC) || (state == MEM_EXEC);
    assign reg_we   = exec && write_en;
    assign flags_we = exec && flags_en;

    // Execute controls ------------------------------
    always_comb begin
        alu_op      = PASS;
        dst_sel     = A;
        operand_sel = OPERAND_MEM;
        write_en    = 1'b0;
        flags_en    = 1'b0;

        case (opcode[1:0])
            2'b10:   src_sel = X;           // STX
            2'b00:   src_sel = Y;           // STY
            default: src_sel = A;           // STA
        endcase

        casez (opcode)
            8'b???_001_01, 8'b???_010_01, 8'b???_011_01: begin
                if (opcode[7:5] != 3'b100) begin        // STA handled by store
                    alu_op   = alu_op_t'({1'b0, opcode[7:5]});
                    write_en = (opcode[7:5] != 3'b110); // CMP keeps A
                    flags_en = 1'b1;
                end
            end
            8'b101_00?_?0, 8'b101_011_?0: begin         // LDX, LDY
                dst_sel  = opcode[1] ? X : Y;
                write_en = 1'b1;
                flags_en = 1'b1;
            end
            8'b11?_000_00: begin                        // CPX, CPY immediate
                alu_op   = CMP;
                dst_sel  = opcode[5] ? X : Y;
                flags_en = 1'b1;
            end
            8'b111_010_00: {alu_op, dst_sel, write_en, flags_en} = {INC, X, 2'b11}; // INX
            8'b110_010_00: {alu_op, dst_sel, write_en, flags_en} = {INC, Y, 2'b11}; // INY
            8'b110_010_10: {alu_op, dst_sel, write_en, flags_en} = {DEC, X, 2'b11}; // DEX
            8'b100_010_00: {alu_op, dst_sel, write_en, flags_en} = {DEC, Y, 2'b11}; // DEY
            8'b101_010_10: {dst_sel, src_sel, operand_sel, write_en, flags_en} =
                           {X, A, OPERAND_REG, 2'b11};                              // TAX
            8'b101_010_00: {dst_sel, src_sel, operand_sel, write_en, flags_en} =
                           {Y, A, OPERAND_REG, 2'b11};                              // TAY
            8'b100_010_10: {dst_sel, src_sel, operand_sel, write_en, flags_en} =
                           {A, X, OPERAND_REG, 2'b11};                              // TXA
            8'b100_110_00: {dst_sel, src_sel, operand_sel, write_en, flags_en} =
                           {A, Y, OPERAND_REG, 2'b11};                              // TYA
            8'b000_110_00: {alu_op, flags_en} = {CLC, 1'b1};
            8'b001_110_00: {alu_op, flags_en} = {SEC, 1'b1};
            8'b101_110_00: {alu_op, flags_en} = {CLV, 1'b1};
            default: write_en = 1'b0;       // JMP, NOP and unknowns
        endcase
    end

endmodule

`default_nettype wire

// File: cpu_regfile.sv
`default_nettype none

module cpu_regfile (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire                        bus_ready,   // Holds all registers when low
    input  wire                        reg_we,
    input  wire                        flags_we,
    input  wire mos_isa_pkg::reg_sel_t dst_sel,
    input  wire mos_isa_pkg::reg_sel_t src_sel,
    input  wire                        operand_sel,
    input  wire mos_bus_pkg::data_t    result,
    input  wire mos_isa_pkg::flags_t   new_flags,
    input  wire mos_bus_pkg::data_t    mem_data,
    output mos_bus_pkg::data_t         a_in,
    output mos_bus_pkg::data_t         b_in,
    output mos_isa_pkg::flags_t        flags,
    output mos_bus_pkg::data_t         store_data,
    input  wire mos_isa_pkg::reg_sel_t debug_sel,
    output mos_bus_pkg::data_t         debug_out
);
    import mos_bus_pkg::*;
    import mos_isa_pkg::*;

    data_t  reg_a;
    data_t  reg_x;
    data_t  reg_y;
    flags_t reg_p;

    function automatic data_t pick(input reg_sel_t sel, input data_t ra, input data_t rx,
                                   input data_t ry, input flags_t rp);
        case (sel)
            A:       pick = ra;
            X:       pick = rx;
            Y:       pick = ry;
            default: pick = rp;
        endcase
    endfunction

    // Operand and view muxes ------------------------------
    assign a_in       = pick(dst_sel, reg_a, reg_x, reg_y, reg_p);
    assign store_data = pick(src_sel, reg_a, reg_x, reg_y, reg_p);   // Also the TXA source
    assign b_in       = (operand_sel == OPERAND_MEM) ? mem_data : store_data;
    assign flags      = reg_p;
    assign debug_out  = pick(debug_sel, reg_a, reg_x, reg_y, reg_p);

    // Write-back ------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            reg_a <= 8'h00;
            reg_x <= 8'h00;
            reg_y <= 8'h00;
            reg_p <= FLAGS_FIXED;
        end else if (bus_ready) begin
            if (reg_we) begin
                case (dst_sel)
                    A:       reg_a <= result;
                    X:       reg_x <= result;
                    Y:       reg_y <= result;
                    default: reg_a <= reg_a;    // P is written via flags only
                endcase
            end
            if (flags_we)
                reg_p <= new_flags | FLAGS_FIXED;
        end
    end

endmodule

`default_nettype wire

// File: cpu_sequencer.sv
`default_nettype none

module cpu_sequencer (
    input  wire                          CLK,
    input  wire                          RESET,
    input  wire                          bus_ready,
    input  wire mos_bus_pkg::data_t      bus_rdata,
    input  wire                          store,       // From decoder
    input  wire mos_bus_pkg::data_t      store_data,
    output mos_bus_pkg::addr_t           bus_addr,
    output mos_bus_pkg::data_t           bus_wdata,
    output logic                         bus_we,
    output logic                         sync,
    output mos_isa_pkg::opcode_t         opcode,
    output mos_isa_pkg::seq_state_t      state
);
    import mos_bus_pkg::*;
    import mos_isa_pkg::*;

    addr_t pc;
    addr_t ea;                              // Effective address
    data_t tmp_lo;                          // Address low byte in flight

    // Opcode classes ------------------------------
    function automatic logic is_zp(input opcode_t op);
        is_zp = (op[4:2] == 3'b001)
             && (op[1:0] == 2'b01 || (op[7:6] == 2'b10 && !op[0]));  // Group 1, LD/ST X Y
    endfunction

    function automatic logic is_abs(input opcode_t op);
        is_abs = ((op[4:2] == 3'b011)
              && (op[1:0] == 2'b01 || (op[7:6] == 2'b10 && !op[0])))
              || (op == OPC_JMP_ABS);
    endfunction

    // Two-byte implied-path opcodes that consume an operand
    function automatic logic has_imm(input opcode_t op);
        has_imm = (op[1:0] == 2'b01 && op[4:2] == 3'b010 && op[7:5] != 3'b100)
               || (op[7:5] == 3'b101 && op[4:2] == 3'b000 && !op[0])     // LDY, LDX
               || (op[7:6] == 2'b11 && op[4:0] == 5'b00000);             // CPY, CPX
    endfunction

    // Bus outputs ------------------------------
    always_comb begin
        case (state)
            MEM_EXEC, STORE, RST_JMP: bus_addr = ea;
            default:                  bus_addr = pc;
        endcase
    end

    assign bus_wdata = store_data;
    assign bus_we    = (state == STORE);
    assign sync      = (state == FETCH);

    // Cycle FSM ------------------------------
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= RST_LO;
            pc     <= RESET_VECTOR;
            opcode <= OPC_NOP;
        end else if (bus_ready) begin
            case (state)
                FETCH: begin
                    opcode <= bus_rdata;
                    pc     <= pc + 16'd1;
                    if (is_zp(bus_rdata))
                        state <= ZP_ADDR;
                    else if (is_abs(bus_rdata))
                        state <= ABS_LO;
                    else
                        state <= IMM_EXEC;  // Immediate, implied, unknown
                end
                IMM_EXEC: begin
                    if (has_imm(opcode))
                        pc <= pc + 16'd1;   // Step past operand
                    state <= FETCH;
                end
                ZP_ADDR: begin
                    ea    <= {ZERO_PAGE_HI, bus_rdata};
                    pc    <= pc + 16'd1;
                    state <= store ? STORE : MEM_EXEC;
                end
                ABS_LO: begin
                    tmp_lo <= bus_rdata;
                    pc     <= pc + 16'd1;
                    state  <= ABS_HI;
                end
                ABS_HI: begin
                    if (opcode == OPC_JMP_ABS) begin
                        pc    <= {bus_rdata, tmp_lo};
                        state <= FETCH;
                    end else begin
                        ea    <= {bus_rdata, tmp_lo};
                        pc    <= pc + 16'd1;
                        state <= store ? STORE : MEM_EXEC;
                    end
                end
                MEM_EXEC, STORE: state <= FETCH;    // Write-back or write lands here
                RST_LO: begin
                    tmp_lo <= bus_rdata;            // FFFC
                    pc     <= pc + 16'd1;
                    state  <= RST_HI;
                end
                RST_HI: begin
                    ea    <= {bus_rdata, tmp_lo};   // FFFD
                    state <= RST_JMP;
                end
                RST_JMP: begin
                    pc    <= ea;
                    state <= FETCH;
                end
                default: state <= RST_LO;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: cpu_top.sv
`default_nettype none

module cpu_top (
    input  wire                        CLK,
    input  wire                        RESET,
    output mos_bus_pkg::addr_t         bus_addr,
    input  wire mos_bus_pkg::data_t    bus_rdata,
    output mos_bus_pkg::data_t         bus_wdata,
    output logic                       bus_we,
    input  wire                        bus_ready,
    output logic                       sync,
    input  wire mos_isa_pkg::reg_sel_t debug_sel,
    output mos_bus_pkg::data_t         debug_out
);
    import mos_bus_pkg::*;
    import mos_isa_pkg::*;

    opcode_t    opcode;
    seq_state_t state;
    alu_op_t    alu_op;
    reg_sel_t   dst_sel;
    reg_sel_t   src_sel;
    logic       operand_sel;
    logic       reg_we;
    logic       flags_we;
    logic       store;
    data_t      a_in;
    data_t      b_in;
    data_t      result;
    data_t      store_data;
    flags_t     flags;
    flags_t     new_flags;

    // Sequencer ------------------------------
    cpu_sequencer cpu_sequencer_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .bus_ready  (bus_ready),
        .bus_rdata  (bus_rdata),
        .store      (store),
        .store_data (store_data),
        .bus_addr   (bus_addr),
        .bus_wdata  (bus_wdata),
        .bus_we     (bus_we),
        .sync       (sync),
        .opcode     (opcode),
        .state      (state)
    );

    cpu_decode cpu_decode_i (
        .opcode      (opcode),
        .state       (state),
        .alu_op      (alu_op),
        .dst_sel     (dst_sel),
        .src_sel     (src_sel),
        .operand_sel (operand_sel),
        .reg_we      (reg_we),
        .flags_we    (flags_we),
        .store       (store)
    );

    // Datapath ------------------------------
    cpu_regfile cpu_regfile_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .bus_ready   (bus_ready),
        .reg_we      (reg_we),
        .flags_we    (flags_we),
        .dst_sel     (dst_sel),
        .src_sel     (src_sel),
        .operand_sel (operand_sel),
        .result      (result),
        .new_flags   (new_flags),
        .mem_data    (bus_rdata),           // Operand straight off the bus
        .a_in        (a_in),
        .b_in        (b_in),
        .flags       (flags),
        .store_data  (store_data),
        .debug_sel   (debug_sel),
        .debug_out   (debug_out)
    );

    cpu_alu cpu_alu_i (
        .op        (alu_op),
        .a_in      (a_in),
        .b_in      (b_in),
        .flags_in  (flags),
        .result    (result),
        .flags_out (new_flags)
    );

endmodule

`default_nettype wire

// File: mos_bus_pkg.sv
`default_nettype none

package mos_bus_pkg;

    // Bus widths ------------------------------
    typedef logic [15:0] addr_t;            // Memory address
    typedef logic [7:0]  data_t;            // Data byte

    // Fixed addresses ------------------------------
    localparam addr_t RESET_VECTOR = 16'hFFFC;  // Low byte of reset vector
    localparam data_t ZERO_PAGE_HI = 8'h00;     // Page of zero-page operands

endpackage

`default_nettype wire

// File: mos_isa_pkg.sv
`default_nettype none

package mos_isa_pkg;

    // Opcode and status ------------------------------
    typedef logic [7:0] opcode_t;           // Latched opcode, aaa_bbb_cc
    typedef logic [7:0] flags_t;            // N V 1 B D I Z C

    localparam int FLAG_N = 7;              // Negative
    localparam int FLAG_V = 6;              // Overflow
    localparam int FLAG_Z = 1;              // Zero
    localparam int FLAG_C = 0;              // Carry

    localparam flags_t FLAGS_FIXED = 8'b0010_0000;  // Bit 5 always set

    localparam opcode_t OPC_JMP_ABS = 8'h4C;    // Only jump kept
    localparam opcode_t OPC_NOP     = 8'hEA;    // Opcode held through reset

    // Sequencer cycles ------------------------------
    typedef enum logic [3:0] {
        FETCH,                              // Opcode read, sync high
        IMM_EXEC,                           // Immediate or implied execute
        ZP_ADDR,                            // Zero-page address byte
        ABS_LO,                             // Absolute address low
        ABS_HI,                             // Absolute address high
        MEM_EXEC,                           // Operand read at EA, execute
        STORE,                              // Write at EA
        RST_LO,                             // Vector low byte
        RST_HI,                             // Vector high byte
        RST_JMP                             // PC loaded from vector
    } seq_state_t;

    // ALU operations ------------------------------
    // Low codes follow the aaa field of the cc=01 group
    typedef enum logic [3:0] {
        ORA  = 4'h0,
        AND  = 4'h1,
        EOR  = 4'h2,
        ADC  = 4'h3,
        PASS = 4'h5,                        // Loads and transfers
        CMP  = 4'h6,
        SBC  = 4'h7,
        INC  = 4'h8,
        DEC  = 4'h9,
        CLC  = 4'hA,
        SEC  = 4'hB,
        CLV  = 4'hC
    } alu_op_t;

    typedef enum logic [1:0] {A, X, Y, P} reg_sel_t;

    localparam logic OPERAND_MEM = 1'b0;    // Second operand from bus
    localparam logic OPERAND_REG = 1'b1;    // Second operand from src_sel

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f all.f &&
./obj_dir/Vtb_cpu | tee /dev/stderr | grep -q "Simulation PASSED" &&
echo "run.sh: pass" ||
{ echo "run.sh: fail"; exit 1; }

// File: tb_clock.sv
`default_nettype none

module tb_clock (
    output logic CLK,
    output logic RESET
);
    initial begin
        CLK   = 1'b0;
        RESET = 1'b1;                       // Held from time zero
    end

    always #10 CLK = ~CLK;                  // Period 20

    initial begin
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;                      // Released on a rising edge
    end

endmodule

`default_nettype wire

// File: tb_cpu.sv
`default_nettype none

module tb_cpu;
    import mos_bus_pkg::*;
    import mos_isa_pkg::*;

    localparam addr_t PROG_BASE    = 16'hC000;
    localparam int    NUM_INSTR    = 60;
    localparam int    WAIT_CYCLES  = 200;  // Per sync wait
    localparam int    LOOP_VISITS  = 4;    // Fetches of the final JMP
    localparam data_t OPS [0:47] = '{
        8'h09, 8'h29, 8'h49, 8'h69, 8'hA9, 8'hC9, 8'hE9, 8'hA2, 8'hA0, 8'hE0, 8'hC0, 8'hEA,
        8'h05, 8'h25, 8'h45, 8'h65, 8'hA5, 8'hC5, 8'hE5, 8'hA6, 8'hA4, 8'h85, 8'h86, 8'h84,
        8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'hAD, 8'hCD, 8'hED, 8'hAE, 8'hAC, 8'h8D, 8'h8E, 8'h8C,
        8'hE8, 8'hC8, 8'hCA, 8'h88, 8'hAA, 8'hA8, 8'h8A, 8'h98, 8'h18, 8'h38, 8'hB8, 8'hEA};

    logic CLK, RESET, bus_we, bus_ready, sync, timed_out;
    addr_t bus_addr, m_pc, end_addr;
    data_t bus_rdata, bus_wdata, debug_out, m_a, m_x, m_y;
    flags_t m_p;
    reg_sel_t debug_sel;
    data_t mem [0:65535];                   // Memory seen by the DUT
    data_t model_mem [0:65535];             // Memory of the model
    addr_t exp_addr_q [$];                  // Stores in program order
    data_t exp_data_q [$];
    logic [31:0] lfsr;
    int addr_errs, data_errs, flag_errs, other_errs, syncs, visits;

    tb_clock tb_clock_i (.CLK(CLK), .RESET(RESET));

    cpu_top cpu_top_i (.CLK(CLK), .RESET(RESET), .bus_addr(bus_addr), .bus_rdata(bus_rdata),
        .bus_wdata(bus_wdata), .bus_we(bus_we), .bus_ready(bus_ready), .sync(sync),
        .debug_sel(debug_sel), .debug_out(debug_out));

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // Taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic int op_length(input data_t op);
        case (op)
            8'hE8, 8'hC8, 8'hCA, 8'h88, 8'hAA, 8'hA8, 8'h8A, 8'h98,
            8'h18, 8'h38, 8'hB8, 8'hEA: return 1;
            8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'hAD, 8'hCD, 8'hED, 8'hAE, 8'hAC,
            8'h8D, 8'h8E, 8'h8C, 8'h4C: return 3;
            default: return 2;
        endcase
    endfunction

    // Memory and bus drive ------------------------------
    assign bus_rdata = mem[bus_addr];       // Same-cycle read

    always @(posedge CLK) begin
        if (bus_ready && bus_we)
            mem[bus_addr] <= bus_wdata;     // Write on completing edge
        bus_ready <= (take_bits(2) != 0);   // Stall one cycle in four
        debug_sel <= reg_sel_t'(take_bits(2));
    end

    // Compare tasks ------------------------------
    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            addr_errs++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            data_errs++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flags(input flags_t got, input flags_t exp);
        if (got !== exp) begin
            flag_errs++;
            $display("Fail %0t: P got %b expected %b", $time, got, exp);
        end
    endtask

    // Reference model ------------------------------
    task automatic set_nz(input data_t v);
        m_p[FLAG_Z] = (v == 8'h00);
        m_p[FLAG_N] = v[7];
    endtask

    // Unsigned sum gives C, signed sum out of range gives V
    task automatic add_carry(input data_t v);
        int sum_u;
        int sum_s;
        sum_u = int'(m_a) + int'(v) + int'(m_p[FLAG_C]);
        sum_s = int'($signed(m_a)) + int'($signed(v)) + int'(m_p[FLAG_C]);
        m_p[FLAG_V] = (sum_s > 127) || (sum_s < -128);
        m_p[FLAG_C] = (sum_u > 255);
        m_a = data_t'(sum_u);
        set_nz(m_a);
    endtask

    task automatic compare(input data_t r, input data_t v);
        m_p[FLAG_C] = (r >= v);
        set_nz(r - v);
    endtask

    task automatic store_model(input addr_t ea, input data_t v);
        model_mem[ea] = v;
        exp_addr_q.push_back(ea);
        exp_data_q.push_back(v);
    endtask

    task automatic exec_model;
        data_t op, b1, b2, v;
        addr_t ea;
        int    len;
        op  = model_mem[m_pc];
        b1  = model_mem[m_pc + 16'd1];
        b2  = model_mem[m_pc + 16'd2];
        len = op_length(op);
        ea  = (len == 3) ? {b2, b1} : {ZERO_PAGE_HI, b1};
        v   = (op[4:2] == 3'b001 || len == 3) ? model_mem[ea] : b1;  // Memory or immediate
        m_pc = m_pc + 16'(len);
        case (op)
            8'h09, 8'h05, 8'h0D: begin m_a = m_a | v; set_nz(m_a); end
            8'h29, 8'h25, 8'h2D: begin m_a = m_a & v; set_nz(m_a); end
            8'h49, 8'h45, 8'h4D: begin m_a = m_a ^ v; set_nz(m_a); end
            8'h69, 8'h65, 8'h6D: add_carry(v);
            8'hE9, 8'hE5, 8'hED: add_carry(~v);     // Subtract as add of inverse
            8'hA9, 8'hA5, 8'hAD: begin m_a = v; set_nz(m_a); end
            8'hA2, 8'hA6, 8'hAE: begin m_x = v; set_nz(m_x); end
            8'hA0, 8'hA4, 8'hAC: begin m_y = v; set_nz(m_y); end
            8'hC9, 8'hC5, 8'hCD: compare(m_a, v);
            8'hE0: compare(m_x, v);
            8'hC0: compare(m_y, v);
            8'h85, 8'h8D: store_model(ea, m_a);
            8'h86, 8'h8E: store_model(ea, m_x);
            8'h84, 8'h8C: store_model(ea, m_y);
            8'hE8: begin m_x = m_x + 8'd1; set_nz(m_x); end
            8'hC8: begin m_y = m_y + 8'd1; set_nz(m_y); end
            8'hCA: begin m_x = m_x - 8'd1; set_nz(m_x); end
            8'h88: begin m_y = m_y - 8'd1; set_nz(m_y); end
            8'hAA: begin m_x = m_a; set_nz(m_x); end
            8'hA8: begin m_y = m_a; set_nz(m_y); end
            8'h8A: begin m_a = m_x; set_nz(m_a); end
            8'h98: begin m_a = m_y; set_nz(m_a); end
            8'h18: m_p[FLAG_C] = 1'b0;
            8'h38: m_p[FLAG_C] = 1'b1;
            8'hB8: m_p[FLAG_V] = 1'b0;
            8'h4C: m_pc = {b2, b1};
            default: m_pc = m_pc;           // NOP
        endcase
    endtask

    // Program and waits ------------------------------
    task automatic build_program;
        addr_t p;
        data_t op;
        int    len;
        for (int i = 0; i < 65536; i++)
            mem[i] = data_t'(i >> 8) * 8'd7 ^ data_t'(i) ^ 8'h3C;    // Whole-address fill
        mem[RESET_VECTOR]         = PROG_BASE[7:0];
        mem[RESET_VECTOR + 16'd1] = PROG_BASE[15:8];
        p = PROG_BASE;
        for (int i = 0; i < NUM_INSTR; i++) begin
            op  = OPS[take_bits(6) % 48];
            len = op_length(op);
            mem[p] = op;
            if (len > 1)
                mem[p + 16'd1] = data_t'(take_bits(8));  // Zp, imm or abs low
            if (len > 2)
                mem[p + 16'd2] = 8'h02;                  // Page 02
            p = p + 16'(len);
        end
        end_addr = p;
        mem[p]         = 8'h4C;             // JMP to itself
        mem[p + 16'd1] = p[7:0];
        mem[p + 16'd2] = p[15:8];
        for (int i = 0; i < 65536; i++)
            model_mem[i] = mem[i];
    endtask

    task automatic wait_sync;
        int n;
        n = 0;
        do begin
            @(posedge CLK);
            n++;
            if (bus_ready && bus_we) begin
                if (exp_addr_q.size() == 0) begin
                    other_errs++;
                    $display("Unexpected write to %h at time %0t", bus_addr, $time);
                end else begin
                    check_addr(bus_addr, exp_addr_q.pop_front(), "store address");
                    check_data(bus_wdata, exp_data_q.pop_front(), "store data");
                end
            end
        end while (!(bus_ready && sync) && n < WAIT_CYCLES);
        if (!(bus_ready && sync)) begin
            timed_out = 1'b1;
            $display("Timeout: no opcode fetch within %0d cycles", WAIT_CYCLES);
        end
    endtask

    // Main sequence ------------------------------
    initial begin
        bus_ready = 1'b0;
        debug_sel = A;
        lfsr      = 32'h54b5;
        timed_out = 1'b0;
        {addr_errs, data_errs, flag_errs, other_errs, syncs, visits} = '0;
        {m_a, m_x, m_y} = '0;
        m_p = 8'h20;                        // Fixed bit only
        build_program();
        m_pc = {mem[RESET_VECTOR + 16'd1], mem[RESET_VECTOR]};
        while (!timed_out && visits < LOOP_VISITS && syncs < 500) begin
            wait_sync();
            if (!timed_out) begin
                if (exp_addr_q.size() != 0) begin
                    other_errs++;
                    $display("A store was never written before fetch at %h", bus_addr);
                    exp_addr_q.delete();
                    exp_data_q.delete();
                end
                check_addr(bus_addr, m_pc, "fetch address");
                case (debug_sel)
                    A:       check_data(debug_out, m_a, "A");
                    X:       check_data(debug_out, m_x, "X");
                    Y:       check_data(debug_out, m_y, "Y");
                    default: check_flags(flags_t'(debug_out), m_p);
                endcase
                if (m_pc == end_addr)
                    visits++;               // Final loop reached again
                exec_model();
                syncs++;
            end
        end
        if (visits < LOOP_VISITS && !timed_out) begin
            other_errs++;
            $display("Program never settled in its final loop");
        end
        $display("Errors: addr %0d data %0d flags %0d other %0d timeout %0d",
                 addr_errs, data_errs, flag_errs, other_errs, timed_out);
        if (addr_errs + data_errs + flag_errs + other_errs == 0 && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
